//--- pw_capture_top.f
+incdir+verilog
verilog/pw_pkg.sv
verilog/pw_async_fifo.sv
verilog/pw_entry_writer.sv
verilog/reg_pw.sv
verilog/pw_capture_top.sv
tests/tb_pw_capture.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pw_capture \
   -f pw_capture_top.f -o tb_pw_capture

output=$(./obj_dir/tb_pw_capture 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'TEST RESULT: PASS'; then
   exit 0
fi
exit 1

//--- tests/tb_pw_capture.sv
// Drives host bus and front end of the capture block; needs a simulator with timing and assertions
`include "pw_params.svh"

module tb_pw_capture import pw_pkg::*; ();

   localparam int PB = `PW_PATTERN_BYTES;
   localparam logic [7:0] ST_EMPTY     = 8'h01 << `PW_STAT_EMPTY;
   localparam logic [7:0] ST_UNDERFLOW = 8'h01 << `PW_STAT_UNDERFLOW;
   localparam logic [7:0] ST_FULL      = 8'h01 << `PW_STAT_FULL;
   localparam logic [7:0] ST_DROPPED   = 8'h01 << `PW_STAT_DROPPED;

   logic              cwusb_clk;
   logic              fe_clk;
   logic              reset_i;
   logic [5:0]        reg_address;
   logic [15:0]       reg_bytecnt;
   logic [7:0]        write_data;
   logic              reg_read;
   logic              reg_write;
   logic              reg_addrvalid;
   logic [7:0]        read_data;
   fe_capture_t       fe_capture;
   logic              fe_capture_wr;
   logic              I_match;
   logic              O_arm;
   logic              O_timestamps_disable;
   logic [15:0]       O_capture_len;
   logic [8*PB-1:0]   O_pattern;
   logic [8*PB-1:0]   O_pattern_mask;
   logic [1:0]        O_pattern_action;
   logic [7:0]        O_pattern_bytes;
   logic              O_fifo_full;

   int unsigned       errors;
   int unsigned       timeouts;
   logic [31:0]       rng_state;
   logic [17:0]       expected_q[$];

   pw_capture_top uut (.*);

   initial begin
      cwusb_clk = 1'b0;
      forever #20 cwusb_clk = ~cwusb_clk;
   end

   initial begin
      fe_clk = 1'b0;
      forever #8 fe_clk = ~fe_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] rand_word();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic fe_capture_t rand_event(input fe_cmd_e cmd);
      fe_capture_t ev;
      logic [31:0] r;
      r = rand_word();
      ev.timestamp = r[15:0];
      ev.data      = r[23:16];
      ev.stat      = r[28:24];
      ev.cmd       = cmd;
      return ev;
   endfunction

   // Expected FIFO word: cmd, then stat/data/short time or the full time
   function automatic logic [17:0] pack_rule(input fe_capture_t ev, input logic ts_off);
      logic [2:0] st;
      st = ts_off ? 3'd0 : ev.timestamp[2:0];
      case (ev.cmd)
         DATA:    return {ev.cmd, ev.stat, ev.data, st};
         STAT:    return {ev.cmd, ev.stat, 8'h00, st};
         TIME:    return {ev.cmd, ev.timestamp};
         default: return {ev.cmd, 16'h0000};
      endcase
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      assert (got == want) else begin
         errors++;
         $display("mismatch %s: got %0h expected %0h", name, got, want);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge cwusb_clk);
   endtask

   task automatic bus_write(input logic [5:0] addr, input logic [15:0] cnt,
                            input logic [7:0] data);
      @(posedge cwusb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= cnt;
      write_data    <= data;
      reg_write     <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(posedge cwusb_clk);
      reg_write     <= 1'b0;
      reg_addrvalid <= 1'b0;
   endtask

   // Byte is on read_data for the cycle after the read strobe
   task automatic bus_read(input logic [5:0] addr, input logic [15:0] cnt,
                           output logic [7:0] data);
      @(posedge cwusb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= cnt;
      reg_read      <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(posedge cwusb_clk);
      reg_read      <= 1'b0;
      reg_addrvalid <= 1'b0;
      @(negedge cwusb_clk);
      data = read_data;
   endtask

   task automatic check_read(input string name, input logic [5:0] addr,
                             input logic [15:0] cnt, input logic [7:0] want);
      logic [7:0] got;
      bus_read(addr, cnt, got);
      check_value(name, 64'(got), 64'(want));
   endtask

   task automatic wait_status(input logic [7:0] mask, input logic [7:0] value,
                              input string what);
      logic [7:0] stat;
      int         tries;
      tries = 0;
      bus_read(`PW_REG_FIFO_STAT, 16'd0, stat);
      while (((stat & mask) != value) && (tries < 40)) begin
         tries++;
         bus_read(`PW_REG_FIFO_STAT, 16'd0, stat);
      end
      if ((stat & mask) != value) begin
         timeouts++;
         $display("timeout while waiting for %s, status stayed at %h", what, stat);
      end
   endtask

   task automatic send_event(input fe_capture_t ev);
      @(posedge fe_clk);
      fe_capture    <= ev;
      fe_capture_wr <= 1'b1;
      @(posedge fe_clk);
      fe_capture_wr <= 1'b0;
   endtask

   // Pop with byte 0, then the two upper bytes of the same entry
   task automatic drain_expected();
      logic [17:0] want;
      logic [7:0]  b0;
      logic [7:0]  b1;
      logic [7:0]  b2;
      while (expected_q.size() > 0) begin
         want = expected_q.pop_front();
         wait_status(ST_EMPTY, 8'h00, "a FIFO entry");
         bus_read(`PW_REG_FIFO_RD, 16'd0, b0);
         bus_read(`PW_REG_FIFO_RD, 16'd1, b1);
         bus_read(`PW_REG_FIFO_RD, 16'd2, b2);
         check_value("fifo byte 0", 64'(b0), 64'(want[7:0]));
         check_value("fifo byte 1", 64'(b1), 64'(want[15:8]));
         check_value("fifo byte 2", 64'(b2), 64'({6'b0, want[17:16]}));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      fe_capture_t   ev;
      logic [7:0]    rd;
      logic [15:0]   cap_len;
      logic [8*PB-1:0] pat;
      logic [8*PB-1:0] mask;
      logic [7:0]    action;
      logic [7:0]    pat_bytes;
      logic [17:0]   last;
      logic          ts_off;
      int            n;
      errors        = 0;
      timeouts      = 0;
      rng_state     = 32'h83f9_3ff1;
      reset_i       = 1'b1;
      reg_address   = '0;
      reg_bytecnt   = '0;
      write_data    = '0;
      reg_read      = 1'b0;
      reg_write     = 1'b0;
      reg_addrvalid = 1'b0;
      fe_capture    = '0;
      fe_capture_wr = 1'b0;
      I_match       = 1'b0;
      repeat (10) @(posedge cwusb_clk);
      reset_i <= 1'b0;

      // Reset state
      @(negedge cwusb_clk);
      check_value("O_arm", 64'(O_arm), 64'h0);
      check_value("O_timestamps_disable", 64'(O_timestamps_disable), 64'h0);
      check_value("O_capture_len", 64'(O_capture_len), 64'h0);
      check_value("O_pattern", 64'(O_pattern), 64'h0);
      check_value("O_pattern_mask", 64'(O_pattern_mask), 64'h0);
      check_value("O_pattern_action", 64'(O_pattern_action), 64'h0);
      check_value("O_pattern_bytes", 64'(O_pattern_bytes), 64'h0);
      check_value("O_fifo_full", 64'(O_fifo_full), 64'h0);
      check_read("fifo status", `PW_REG_FIFO_STAT, 16'd0, ST_EMPTY);

      // Settings, little-endian by bytecnt
      cap_len   = 16'(rand_word());
      action    = {6'b0, 2'(rand_word())};
      pat_bytes = 8'(rand_word());
      for (int i = 0; i < 2; i++)
         bus_write(`PW_REG_CAPTURE_LEN, 16'(i), cap_len[i*8 +: 8]);
      for (int i = 0; i < PB; i++) begin
         pat[i*8 +: 8]  = 8'(rand_word());
         mask[i*8 +: 8] = 8'(rand_word());
         bus_write(`PW_REG_PATTERN, 16'(i), pat[i*8 +: 8]);
         bus_write(`PW_REG_PATTERN_MASK, 16'(i), mask[i*8 +: 8]);
      end
      bus_write(`PW_REG_PATTERN_ACTION, 16'd0, action);
      bus_write(`PW_REG_PATTERN_BYTES, 16'd0, pat_bytes);
      bus_write(`PW_REG_TIMESTAMPS_DISABLE, 16'd0, 8'h01);
      @(negedge cwusb_clk);
      check_value("O_capture_len", 64'(O_capture_len), 64'(cap_len));
      check_value("O_pattern", 64'(O_pattern), 64'(pat));
      check_value("O_pattern_mask", 64'(O_pattern_mask), 64'(mask));
      check_value("O_pattern_action", 64'(O_pattern_action), 64'(action));
      check_value("O_pattern_bytes", 64'(O_pattern_bytes), 64'(pat_bytes));
      check_value("O_timestamps_disable", 64'(O_timestamps_disable), 64'h1);
      for (int i = 0; i < 2; i++)
         check_read("capture_len byte", `PW_REG_CAPTURE_LEN, 16'(i), cap_len[i*8 +: 8]);
      for (int i = 0; i < PB; i++) begin
         check_read("pattern byte", `PW_REG_PATTERN, 16'(i), pat[i*8 +: 8]);
         check_read("pattern_mask byte", `PW_REG_PATTERN_MASK, 16'(i), mask[i*8 +: 8]);
      end
      check_read("pattern_action", `PW_REG_PATTERN_ACTION, 16'd0, action);
      check_read("pattern_bytes", `PW_REG_PATTERN_BYTES, 16'd0, pat_bytes);
      check_read("timestamps_disable", `PW_REG_TIMESTAMPS_DISABLE, 16'd0, 8'h01);

      // Packing, first without timestamps, then with them
      ts_off = 1'b1;
      for (int pass = 0; pass < 2; pass++) begin
         if (pass == 1) begin
            ts_off = 1'b0;
            bus_write(`PW_REG_TIMESTAMPS_DISABLE, 16'd0, 8'h00);
         end
         for (int k = 0; k < 9; k++) begin
            ev = rand_event(fe_cmd_e'(2'(k % 3)));
            send_event(ev);
            if (!(ts_off && ev.cmd == TIME))
               expected_q.push_back(pack_rule(ev, ts_off));
         end
         drain_expected();
         // Quiet time so a stray TIME entry would show up
         idle(8);
         check_read("fifo status after drain", `PW_REG_FIFO_STAT, 16'd0, ST_EMPTY);
      end

      // Overflow keeps the first 16 entries
      for (int k = 0; k < 20; k++) begin
         ev = rand_event(DATA);
         send_event(ev);
         if (k < 16)
            expected_q.push_back(pack_rule(ev, ts_off));
      end
      wait_status(ST_FULL | ST_DROPPED, ST_FULL | ST_DROPPED, "full and dropped");
      @(negedge cwusb_clk);
      check_value("O_fifo_full", 64'(O_fifo_full), 64'h1);
      last = expected_q[$];
      drain_expected();
      bus_read(`PW_REG_FIFO_RD, 16'd0, rd);
      check_value("fifo byte 0 after empty pop", 64'(rd), 64'(last[7:0]));
      check_read("fifo status after underflow", `PW_REG_FIFO_STAT, 16'd0,
                 ST_EMPTY | ST_UNDERFLOW | ST_DROPPED);

      // Arm with stale entries flushes them first
      for (int k = 0; k < 3; k++)
         send_event(rand_event(DATA));
      wait_status(ST_EMPTY, 8'h00, "entries before arm");
      idle(4);
      bus_write(`PW_REG_ARM, 16'd0, 8'h01);
      n = 0;
      @(negedge cwusb_clk);
      while (!O_arm && n < 30) begin
         n++;
         @(negedge cwusb_clk);
      end
      if (!O_arm) begin
         timeouts++;
         $display("timeout: O_arm did not rise after the flush");
      end
      check_read("fifo status after flush", `PW_REG_FIFO_STAT, 16'd0, ST_EMPTY);

      // Arm on an empty FIFO, no flush
      bus_write(`PW_REG_ARM, 16'd0, 8'h00);
      idle(2);
      @(negedge cwusb_clk);
      check_value("O_arm before arm write", 64'(O_arm), 64'h0);
      bus_write(`PW_REG_ARM, 16'd0, 8'h01);
      @(negedge cwusb_clk);
      check_value("O_arm one cycle after write", 64'(O_arm), 64'h0);
      @(negedge cwusb_clk);
      check_value("O_arm two cycles after write", 64'(O_arm), 64'h1);

      // Match pulse disarms
      @(posedge cwusb_clk);
      I_match <= 1'b1;
      @(posedge cwusb_clk);
      I_match <= 1'b0;
      n = 0;
      @(negedge cwusb_clk);
      while (O_arm && n < 2) begin
         n++;
         @(negedge cwusb_clk);
      end
      check_value("O_arm after match", 64'(O_arm), 64'h0);
      check_read("arm readback", `PW_REG_ARM, 16'd0, 8'h00);

      idle(2);
      $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- verilog/pw_async_fifo.sv
// Dual-clock FIFO; reset_i must be held long enough to be seen in both clock domains
`include "pw_params.svh"

module pw_async_fifo import pw_pkg::*; (
   input  logic        wr_clk,
   input  logic        rd_clk,
   input  logic        reset_i,
   input  logic        wr_en,
   input  fifo_entry_t din,
   output logic        full,
   input  logic        rd_en,
   output fifo_entry_t dout,
   output logic        empty,
   output logic        underflow
);

   localparam int AW = `PW_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   fifo_entry_t mem [DEPTH];

   logic [AW:0] wr_bin;
   logic [AW:0] wr_gray;
   logic [AW:0] rd_bin;
   logic [AW:0] rd_gray;
   logic [AW:0] rd_gray_meta;
   logic [AW:0] rd_gray_sync;
   logic [AW:0] wr_gray_meta;
   logic [AW:0] wr_gray_sync;
   logic [AW:0] wr_bin_next;
   logic [AW:0] rd_bin_next;
   logic        do_rd;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   assign wr_bin_next = wr_bin + 1'b1;
   assign rd_bin_next = rd_bin + 1'b1;

   // Full when the top two gray bits differ and the rest match
   assign full  = (wr_gray == {~rd_gray_sync[AW:AW-1], rd_gray_sync[AW-2:0]});
   assign empty = (rd_gray == wr_gray_sync);
   assign do_rd = rd_en & ~empty;

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge wr_clk) begin
      if (reset_i) begin
         wr_bin       <= '0;
         wr_gray      <= '0;
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end
      else begin
         rd_gray_meta <= rd_gray;
         rd_gray_sync <= rd_gray_meta;
         if (wr_en) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
         end
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_en)
         mem[wr_bin[AW-1:0]] <= din;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         rd_bin       <= '0;
         rd_gray      <= '0;
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
         underflow    <= 1'b0;
         dout         <= '0;
      end
      else begin
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
         // Pop on empty only flags, output holds
         underflow    <= rd_en & empty;
         if (do_rd) begin
            dout    <= mem[rd_bin[AW-1:0]];
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
         end
      end
   end

   // Writer has to drop events itself once full is up
   a_no_write_when_full: assert property (@(posedge wr_clk) disable iff (reset_i)
      !(wr_en && full));

endmodule

//--- verilog/pw_capture_top.sv
// Capture top; decoder and matcher are external, reset_i must span both clock domains
`include "pw_params.svh"

module pw_capture_top import pw_pkg::*; (
   input  logic                           cwusb_clk,
   input  logic                           reset_i,
   input  logic [5:0]                     reg_address,
   input  logic [15:0]                    reg_bytecnt,
   input  logic [7:0]                     write_data,
   input  logic                           reg_read,
   input  logic                           reg_write,
   input  logic                           reg_addrvalid,
   output logic [7:0]                     read_data,
   input  logic                           fe_clk,
   input  fe_capture_t                    fe_capture,
   input  logic                           fe_capture_wr,
   input  logic                           I_match,
   output logic                           O_arm,
   output logic                           O_timestamps_disable,
   output logic [15:0]                    O_capture_len,
   output logic [8*`PW_PATTERN_BYTES-1:0] O_pattern,
   output logic [8*`PW_PATTERN_BYTES-1:0] O_pattern_mask,
   output logic [1:0]                     O_pattern_action,
   output logic [7:0]                     O_pattern_bytes,
   output logic                           O_fifo_full
);

   fifo_entry_t fifo_din;
   fifo_entry_t fifo_dout;
   logic        fifo_wr_en;
   logic        fifo_rd_en;
   logic        fifo_full;
   logic        fifo_empty;
   logic        fifo_underflow;
   logic        flushing;
   logic        dropped;

   // Raw fe_clk level
   assign O_fifo_full = fifo_full;

   reg_pw u_reg_pw (
      .cwusb_clk            (cwusb_clk),
      .reset_i              (reset_i),
      .reg_address          (reg_address),
      .reg_bytecnt          (reg_bytecnt),
      .write_data           (write_data),
      .reg_read             (reg_read),
      .reg_write            (reg_write),
      .reg_addrvalid        (reg_addrvalid),
      .read_data            (read_data),
      .I_match              (I_match),
      .O_arm                (O_arm),
      .O_timestamps_disable (O_timestamps_disable),
      .O_capture_len        (O_capture_len),
      .O_pattern            (O_pattern),
      .O_pattern_mask       (O_pattern_mask),
      .O_pattern_action     (O_pattern_action),
      .O_pattern_bytes      (O_pattern_bytes),
      .fifo_dout            (fifo_dout),
      .fifo_empty           (fifo_empty),
      .fifo_underflow       (fifo_underflow),
      .fifo_full_fe         (fifo_full),
      .dropped_fe           (dropped),
      .fifo_rd_en           (fifo_rd_en),
      .flushing             (flushing)
   );

   pw_entry_writer u_writer (
      .fe_clk             (fe_clk),
      .reset_i            (reset_i),
      .fe_capture         (fe_capture),
      .fe_capture_wr      (fe_capture_wr),
      .timestamps_disable (O_timestamps_disable),
      .flushing           (flushing),
      .fifo_full          (fifo_full),
      .wr_en              (fifo_wr_en),
      .entry              (fifo_din),
      .dropped            (dropped)
   );

   pw_async_fifo u_fifo (
      .wr_clk    (fe_clk),
      .rd_clk    (cwusb_clk),
      .reset_i   (reset_i),
      .wr_en     (fifo_wr_en),
      .din       (fifo_din),
      .full      (fifo_full),
      .rd_en     (fifo_rd_en),
      .dout      (fifo_dout),
      .empty     (fifo_empty),
      .underflow (fifo_underflow)
   );

endmodule

//--- verilog/pw_entry_writer.sv
// fe_clk side; timestamps_disable is a quasi-static setting and is used here unsynchronized
module pw_entry_writer import pw_pkg::*; (
   input  logic        fe_clk,
   input  logic        reset_i,
   input  fe_capture_t fe_capture,
   input  logic        fe_capture_wr,
   input  logic        timestamps_disable,
   input  logic        flushing,
   input  logic        fifo_full,
   output logic        wr_en,
   output fifo_entry_t entry,
   output logic        dropped
);

   fifo_entry_t packed_entry;
   logic        pend;
   logic        flush_meta;
   logic        flush_sync;

   // Pack the event into one of the two payload layouts
   always_comb begin
      packed_entry     = '0;
      packed_entry.cmd = fe_capture.cmd;
      case (fe_capture.cmd)
         DATA: begin
            packed_entry.payload.samp.stat = fe_capture.stat;
            packed_entry.payload.samp.data = fe_capture.data;
            packed_entry.payload.samp.short_time =
               timestamps_disable ? 3'd0 : fe_capture.timestamp[2:0];
         end
         STAT: begin
            packed_entry.payload.samp.stat = fe_capture.stat;
            packed_entry.payload.samp.short_time =
               timestamps_disable ? 3'd0 : fe_capture.timestamp[2:0];
         end
         TIME:    packed_entry.payload.stamp = fe_capture.timestamp;
         default: packed_entry.payload = '0;
      endcase
   end

   always_ff @(posedge fe_clk) begin
      if (fe_capture_wr)
         entry <= packed_entry;
   end

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         pend       <= 1'b0;
         dropped    <= 1'b0;
         flush_meta <= 1'b0;
         flush_sync <= 1'b0;
      end
      else begin
         flush_meta <= flushing;
         flush_sync <= flush_meta;
         // No TIME entries without timestamps
         pend <= fe_capture_wr & ~(timestamps_disable && fe_capture.cmd == TIME);
         if (flush_sync)
            dropped <= 1'b0;
         else if (pend && fifo_full)
            dropped <= 1'b1;
      end
   end

   // A pending entry that meets full is lost
   assign wr_en = pend & ~fifo_full;

endmodule

//--- verilog/pw_params.svh
// Register map and sizes; addresses are 6-bit codes, multi-byte registers are little-endian
`ifndef PW_PARAMS_SVH
`define PW_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Sizes
////////////////////////////////////////////////////////////////////////////

// Pattern matcher width in bytes
`define PW_PATTERN_BYTES 8

// FIFO address width, depth is 2**AW entries
`define PW_FIFO_AW 4

////////////////////////////////////////////////////////////////////////////
// Register addresses
////////////////////////////////////////////////////////////////////////////

`define PW_REG_ARM                6'd1
`define PW_REG_TIMESTAMPS_DISABLE 6'd2
`define PW_REG_CAPTURE_LEN        6'd3
`define PW_REG_PATTERN            6'd4
`define PW_REG_PATTERN_MASK       6'd5
`define PW_REG_PATTERN_ACTION     6'd6
`define PW_REG_PATTERN_BYTES      6'd7
`define PW_REG_FIFO_STAT          6'd8
// Three bytes per entry, byte 0 pops
`define PW_REG_FIFO_RD            6'd9

////////////////////////////////////////////////////////////////////////////
// FIFO status byte bits
////////////////////////////////////////////////////////////////////////////

`define PW_STAT_EMPTY     0
`define PW_STAT_UNDERFLOW 1
`define PW_STAT_FULL      2
`define PW_STAT_DROPPED   3

`endif

//--- verilog/pw_pkg.sv
// Capture types; the FIFO payload is only meaningful together with the entry's cmd field
package pw_pkg;

   // Kind of capture event from the front end
   typedef enum logic [1:0] {
      DATA = 2'd0,
      STAT = 2'd1,
      TIME = 2'd2
   } fe_cmd_e;

   // One front-end event, 31 bits
   typedef struct packed {
      logic [15:0] timestamp;
      logic [7:0]  data;
      logic [4:0]  stat;
      fe_cmd_e     cmd;
   } fe_capture_t;

   // DATA and STAT layout of the payload word
   typedef struct packed {
      logic [4:0] stat;
      logic [7:0] data;
      logic [2:0] short_time;
   } fifo_samp_t;

   // Same 16 bits, decoded by cmd
   typedef union packed {
      fifo_samp_t  samp;
      logic [15:0] stamp;
   } fifo_payload_u;

   // FIFO word, cmd in 17:16
   typedef struct packed {
      fe_cmd_e       cmd;
      fifo_payload_u payload;
   } fifo_entry_t;

endpackage

//--- verilog/reg_pw.sv
// Host registers; fifo_full_fe and dropped_fe come from fe_clk, reads with bytecnt past size alias
`include "pw_params.svh"

module reg_pw import pw_pkg::*; (
   input  logic                           cwusb_clk,
   input  logic                           reset_i,
   input  logic [5:0]                     reg_address,
   input  logic [15:0]                    reg_bytecnt,
   input  logic [7:0]                     write_data,
   input  logic                           reg_read,
   input  logic                           reg_write,
   input  logic                           reg_addrvalid,
   output logic [7:0]                     read_data,
   input  logic                           I_match,
   output logic                           O_arm,
   output logic                           O_timestamps_disable,
   output logic [15:0]                    O_capture_len,
   output logic [8*`PW_PATTERN_BYTES-1:0] O_pattern,
   output logic [8*`PW_PATTERN_BYTES-1:0] O_pattern_mask,
   output logic [1:0]                     O_pattern_action,
   output logic [7:0]                     O_pattern_bytes,
   input  fifo_entry_t                    fifo_dout,
   input  logic                           fifo_empty,
   input  logic                           fifo_underflow,
   input  logic                           fifo_full_fe,
   input  logic                           dropped_fe,
   output logic                           fifo_rd_en,
   output logic                           flushing
);

   localparam int PB_AW = $clog2(`PW_PATTERN_BYTES);

   logic                host_wr;
   logic                host_rd;
   logic                arm_write;
   logic                flush_start;
   logic                reg_arm;
   logic                reg_arm_r;
   logic                arm_wr_q;
   logic                underflow_sticky;
   logic [1:0]          fe_meta;
   logic [1:0]          fe_sync;
   logic [7:0]          fifo_status;
   logic [7:0]          reg_read_data;
   logic [PB_AW-1:0]    pat_idx;

   assign host_wr     = reg_addrvalid & reg_write;
   assign host_rd     = reg_addrvalid & reg_read;
   assign arm_write   = host_wr && (reg_address == `PW_REG_ARM);
   assign flush_start = arm_wr_q & ~fifo_empty;
   assign pat_idx     = reg_bytecnt[PB_AW-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Settings
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         O_timestamps_disable <= 1'b0;
         O_capture_len        <= '0;
         O_pattern            <= '0;
         O_pattern_mask       <= '0;
         O_pattern_action     <= '0;
         O_pattern_bytes      <= '0;
      end
      else if (host_wr) begin
         case (reg_address)
            `PW_REG_TIMESTAMPS_DISABLE: O_timestamps_disable <= write_data[0];
            `PW_REG_CAPTURE_LEN:    O_capture_len[reg_bytecnt[0]*8 +: 8] <= write_data;
            `PW_REG_PATTERN:        O_pattern[pat_idx*8 +: 8] <= write_data;
            `PW_REG_PATTERN_MASK:   O_pattern_mask[pat_idx*8 +: 8] <= write_data;
            `PW_REG_PATTERN_ACTION: O_pattern_action <= write_data[1:0];
            `PW_REG_PATTERN_BYTES:  O_pattern_bytes <= write_data;
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Arm and flush
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         reg_arm   <= 1'b0;
         reg_arm_r <= 1'b0;
         arm_wr_q  <= 1'b0;
         flushing  <= 1'b0;
      end
      else begin
         // Host write wins over a match in the same cycle
         if (arm_write)
            reg_arm <= write_data[0];
         else if (I_match)
            reg_arm <= 1'b0;
         reg_arm_r <= reg_arm;
         arm_wr_q  <= arm_write & write_data[0];
         if (fifo_empty)
            flushing <= 1'b0;
         else if (arm_wr_q)
            flushing <= 1'b1;
      end
   end

   // Armed level held back until the stale entries are gone
   assign O_arm = reg_arm_r & ~flushing;

   assign fifo_rd_en = (host_rd && (reg_address == `PW_REG_FIFO_RD) && (reg_bytecnt == 16'd0))
                     || (flushing && !fifo_empty);

   ////////////////////////////////////////////////////////////////////////////
   // Status
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         fe_meta          <= '0;
         fe_sync          <= '0;
         underflow_sticky <= 1'b0;
      end
      else begin
         // Bit 1 full, bit 0 dropped
         fe_meta <= {fifo_full_fe, dropped_fe};
         fe_sync <= fe_meta;
         if (flush_start)
            underflow_sticky <= 1'b0;
         else if (fifo_underflow)
            underflow_sticky <= 1'b1;
      end
   end

   always_comb begin
      fifo_status                     = '0;
      fifo_status[`PW_STAT_EMPTY]     = fifo_empty;
      fifo_status[`PW_STAT_UNDERFLOW] = underflow_sticky;
      fifo_status[`PW_STAT_FULL]      = fe_sync[1];
      fifo_status[`PW_STAT_DROPPED]   = fe_sync[0];
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (host_rd) begin
         case (reg_address)
            `PW_REG_ARM:                reg_read_data <= {7'b0, reg_arm};
            `PW_REG_TIMESTAMPS_DISABLE: reg_read_data <= {7'b0, O_timestamps_disable};
            `PW_REG_CAPTURE_LEN:    reg_read_data <= O_capture_len[reg_bytecnt[0]*8 +: 8];
            `PW_REG_PATTERN:        reg_read_data <= O_pattern[pat_idx*8 +: 8];
            `PW_REG_PATTERN_MASK:   reg_read_data <= O_pattern_mask[pat_idx*8 +: 8];
            `PW_REG_PATTERN_ACTION: reg_read_data <= {6'b0, O_pattern_action};
            `PW_REG_PATTERN_BYTES:  reg_read_data <= O_pattern_bytes;
            `PW_REG_FIFO_STAT:      reg_read_data <= fifo_status;
            default:                reg_read_data <= 8'h00;
         endcase
      end
      else
         reg_read_data <= 8'h00;
   end

   // FIFO bytes straight from the registered FIFO output
   always_comb begin
      if (reg_address == `PW_REG_FIFO_RD) begin
         case (reg_bytecnt)
            16'd0:   read_data = fifo_dout.payload[7:0];
            16'd1:   read_data = fifo_dout.payload[15:8];
            16'd2:   read_data = {6'b0, fifo_dout.cmd};
            default: read_data = 8'h00;
         endcase
      end
      else
         read_data = reg_read_data;
   end

   // Arm still set in the first cycle of a flush
   a_flush_needs_arm: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      $rose(flushing) |-> reg_arm);

endmodule
